//--- src/glb_cfg_pkg.sv
/*
 * Shared widths, counts and link types for the global buffer configuration path.
 * Address layout from the LSB up: bank word address, bank select, tile select.
 * NUM_TILES and BANKS_PER_TILE must fit in their select fields.
 */
`default_nettype none

package glb_cfg_pkg;

    localparam int NUM_TILES           = 4;
    localparam int BANKS_PER_TILE      = 2;
    localparam int BANK_ADDR_WIDTH     = 8;
    localparam int BANK_SEL_ADDR_WIDTH = 1;
    localparam int TILE_SEL_ADDR_WIDTH = 2;
    localparam int CFG_ADDR_WIDTH      = BANK_ADDR_WIDTH + BANK_SEL_ADDR_WIDTH
                                         + TILE_SEL_ADDR_WIDTH;
    localparam int CFG_DATA_WIDTH      = 32;

    localparam int BANK_DEPTH   = 1 << BANK_ADDR_WIDTH;  // Words per bank
    localparam int BANK_SEL_LSB = BANK_ADDR_WIDTH;
    localparam int TILE_SEL_LSB = BANK_ADDR_WIDTH + BANK_SEL_ADDR_WIDTH;

    typedef logic [CFG_ADDR_WIDTH-1:0]      cfg_addr_t;
    typedef logic [BANK_ADDR_WIDTH-1:0]     bank_addr_t;
    typedef logic [TILE_SEL_ADDR_WIDTH-1:0] tile_id_t;
    typedef logic [CFG_DATA_WIDTH-1:0]      cfg_data_t;

    // Host to tile and tile to tile
    typedef struct packed {
        logic      wr_en;
        logic      wr_clk_en;
        cfg_addr_t wr_addr;
        cfg_data_t wr_data;
        logic      rd_en;
        logic      rd_clk_en;
        cfg_addr_t rd_addr;
    } cfg_req_t;

    // Controller to bank, addresses already stripped to the word offset
    typedef struct packed {
        logic       wr_en;
        logic       wr_clk_en;
        bank_addr_t wr_addr;
        cfg_data_t  wr_data;
        logic       rd_en;
        logic       rd_clk_en;
        bank_addr_t rd_addr;
    } bank_req_t;

    typedef struct packed {
        cfg_data_t rd_data;
        logic      rd_data_valid;
    } cfg_rsp_t;

endpackage

`default_nettype wire

//--- src/glb_sram_bank.sv
/*
 * One configuration SRAM bank, word addressed, one-cycle registered read.
 * Write needs wr_en and wr_clk_en, read needs rd_en and rd_clk_en.
 * A read and a write to the same word in one cycle returns the old word.
 * Reset clears the read valid only; memory contents are undefined after power-up.
 */
`timescale 1ns/1ps
`default_nettype none

module glb_sram_bank
    import glb_cfg_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  bank_req_t req,
    output cfg_rsp_t  rsp
);

    cfg_data_t mem [BANK_DEPTH];

    logic      wr_fire;
    logic      rd_fire;
    cfg_data_t rd_data_q;
    logic      rd_valid_q;

    // Clock enables act as plain qualifying levels
    assign wr_fire = req.wr_en & req.wr_clk_en;
    assign rd_fire = req.rd_en & req.rd_clk_en;

    always_ff @(posedge clk) begin
        if (wr_fire) begin
            mem[req.wr_addr] <= req.wr_data;
        end
    end

    // Read data holds its last value between reads
    always_ff @(posedge clk) begin
        if (rd_fire) begin
            rd_data_q <= mem[req.rd_addr];
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rd_valid_q <= 1'b0;
        end else begin
            rd_valid_q <= rd_fire;  // One-cycle pulse per accepted read
        end
    end

    assign rsp.rd_data       = rd_data_q;
    assign rsp.rd_data_valid = rd_valid_q;

endmodule

`default_nettype wire

//--- src/glb_sram_cfg_ctrl.sv
/*
 * Per-tile configuration controller.
 * Bank enables decode combinationally from the west request; the full request
 * is registered east. Read data returns west registered, two cycles after a
 * local bank read. A local return wins over est_rsp and drops it, so the host
 * must never schedule two returns into the same cycle.
 */
`timescale 1ns/1ps
`default_nettype none

module glb_sram_cfg_ctrl
    import glb_cfg_pkg::*;
#(
    parameter tile_id_t TILE_ID = '0
) (
    input  logic      clk,
    input  logic      reset,
    input  cfg_req_t  wst_req,
    output cfg_rsp_t  wst_rsp,
    output cfg_req_t  est_req,
    input  cfg_rsp_t  est_rsp,
    output bank_req_t bank_req [BANKS_PER_TILE],
    input  cfg_rsp_t  bank_rsp [BANKS_PER_TILE]
);

    logic                      wr_tile_hit;
    logic                      rd_tile_hit;
    logic [BANKS_PER_TILE-1:0] bank_rd;     // Read accepted by a bank this cycle
    logic [BANKS_PER_TILE-1:0] bank_rd_d1;  // Which bank has data coming back
    cfg_rsp_t                  rsp_next;

    assign wr_tile_hit = (wst_req.wr_addr[TILE_SEL_LSB +: TILE_SEL_ADDR_WIDTH] == TILE_ID);
    assign rd_tile_hit = (wst_req.rd_addr[TILE_SEL_LSB +: TILE_SEL_ADDR_WIDTH] == TILE_ID);

    for (genvar i = 0; i < BANKS_PER_TILE; i++) begin : g_bank_dec
        logic wr_bank_hit;
        logic rd_bank_hit;

        assign wr_bank_hit = (wst_req.wr_addr[BANK_SEL_LSB +: BANK_SEL_ADDR_WIDTH]
                              == BANK_SEL_ADDR_WIDTH'(i));
        assign rd_bank_hit = (wst_req.rd_addr[BANK_SEL_LSB +: BANK_SEL_ADDR_WIDTH]
                              == BANK_SEL_ADDR_WIDTH'(i));

        // Strobes gated by tile and bank match, the rest fans out to all banks
        assign bank_req[i].wr_en     = wst_req.wr_en & wr_tile_hit & wr_bank_hit;
        assign bank_req[i].wr_clk_en = wst_req.wr_clk_en;
        assign bank_req[i].wr_addr   = wst_req.wr_addr[BANK_ADDR_WIDTH-1:0];
        assign bank_req[i].wr_data   = wst_req.wr_data;
        assign bank_req[i].rd_en     = wst_req.rd_en & rd_tile_hit & rd_bank_hit;
        assign bank_req[i].rd_clk_en = wst_req.rd_clk_en;
        assign bank_req[i].rd_addr   = wst_req.rd_addr[BANK_ADDR_WIDTH-1:0];

        // A read with its clock enable low never claims the return slot
        assign bank_rd[i] = bank_req[i].rd_en & wst_req.rd_clk_en;
    end

    // Return mux, local bank first, otherwise pass the east return through
    always_comb begin
        rsp_next = est_rsp;
        for (int i = 0; i < BANKS_PER_TILE; i++) begin
            if (bank_rd_d1[i]) begin
                rsp_next = bank_rsp[i];
            end
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            est_req    <= '0;
            wst_rsp    <= '0;
            bank_rd_d1 <= '0;
        end else begin
            est_req    <= wst_req;   // One hop per cycle
            wst_rsp    <= rsp_next;
            bank_rd_d1 <= bank_rd;
        end
    end

endmodule

`default_nettype wire

//--- src/glb_tile.sv
/*
 * One global buffer tile: a configuration controller and its SRAM banks.
 * TILE_ID is fixed per instance and must be unique along the chain.
 */
`timescale 1ns/1ps
`default_nettype none

module glb_tile
    import glb_cfg_pkg::*;
#(
    parameter tile_id_t TILE_ID = '0
) (
    input  logic     clk,
    input  logic     reset,
    input  cfg_req_t wst_req,
    output cfg_rsp_t wst_rsp,
    output cfg_req_t est_req,
    input  cfg_rsp_t est_rsp
);

    bank_req_t bank_req [BANKS_PER_TILE];
    cfg_rsp_t  bank_rsp [BANKS_PER_TILE];

    glb_sram_cfg_ctrl #(
        .TILE_ID (TILE_ID)
    ) u_ctrl (
        .clk      (clk),
        .reset    (reset),
        .wst_req  (wst_req),
        .wst_rsp  (wst_rsp),
        .est_req  (est_req),
        .est_rsp  (est_rsp),
        .bank_req (bank_req),
        .bank_rsp (bank_rsp)
    );

    // Bank index matches the bank-select field value
    for (genvar b = 0; b < BANKS_PER_TILE; b++) begin : g_bank
        glb_sram_bank u_bank (
            .clk   (clk),
            .reset (reset),
            .req   (bank_req[b]),
            .rsp   (bank_rsp[b])
        );
    end

endmodule

`default_nettype wire

//--- src/glb_sram_cfg_chain.sv
/*
 * Configuration access chain over NUM_TILES tiles, entered at tile 0.
 * Writes reach tile k after k cycles; reads to tile k return after 2k+2.
 * No back-pressure; the host keeps return cycles of in-flight reads distinct.
 */
`timescale 1ns/1ps
`default_nettype none

module glb_sram_cfg_chain
    import glb_cfg_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  cfg_req_t wst_req,
    output cfg_rsp_t wst_rsp
);

    cfg_req_t req_link [NUM_TILES];      // West request of tile k
    cfg_rsp_t rsp_link [NUM_TILES + 1];  // West response of tile k

    assign req_link[0]         = wst_req;
    assign rsp_link[NUM_TILES] = '0;     // Nothing returns from past the east end
    assign wst_rsp             = rsp_link[0];

    for (genvar k = 0; k < NUM_TILES; k++) begin : g_tile
        if (k < NUM_TILES - 1) begin : g_mid
            glb_tile #(
                .TILE_ID (tile_id_t'(k))
            ) u_tile (
                .clk     (clk),
                .reset   (reset),
                .wst_req (req_link[k]),
                .wst_rsp (rsp_link[k]),
                .est_req (req_link[k+1]),
                .est_rsp (rsp_link[k+1])
            );
        end else begin : g_last
            // East request of the last tile goes nowhere
            glb_tile #(
                .TILE_ID (tile_id_t'(k))
            ) u_tile (
                .clk     (clk),
                .reset   (reset),
                .wst_req (req_link[k]),
                .wst_rsp (rsp_link[k]),
                .est_req (),
                .est_rsp (rsp_link[k+1])
            );
        end
    end

endmodule

`default_nettype wire

//--- dv/glb_sram_cfg_assertions.sv
/*
 * Concurrent checks bound into every configuration controller.
 * The local return check assumes the fixed bank register plus return register.
 * All checks are off while reset is high.
 */
`timescale 1ns/1ps
`default_nettype none

module glb_sram_cfg_assertions
    import glb_cfg_pkg::*;
(
    input logic                      clk,
    input logic                      reset,
    input cfg_req_t                  wst_req,
    input cfg_rsp_t                  wst_rsp,
    input cfg_req_t                  est_req,
    input bank_req_t                 bank_req [BANKS_PER_TILE],
    input logic [BANKS_PER_TILE-1:0] bank_rd
);

    logic [BANKS_PER_TILE-1:0] wr_en_vec;
    logic [BANKS_PER_TILE-1:0] rd_en_vec;

    always_comb begin
        for (int i = 0; i < BANKS_PER_TILE; i++) begin
            wr_en_vec[i] = bank_req[i].wr_en;
            rd_en_vec[i] = bank_req[i].rd_en;
        end
    end

    a_one_wr_bank: assert property (@(posedge clk) disable iff (reset)
        $onehot0(wr_en_vec))
        else $error("More than one bank write enable high in one cycle");

    a_one_rd_bank: assert property (@(posedge clk) disable iff (reset)
        $onehot0(rd_en_vec))
        else $error("More than one bank read enable high in one cycle");

    // Bank register, then return register
    a_local_return: assert property (@(posedge clk) disable iff (reset)
        (|bank_rd) |-> ##2 wst_rsp.rd_data_valid)
        else $error("Local bank read did not return two cycles later");

    a_east_forward: assert property (@(posedge clk) disable iff (reset)
        !$past(reset) |-> (est_req == $past(wst_req)))
        else $error("East request is not the west request delayed by one cycle");

endmodule

bind glb_sram_cfg_ctrl glb_sram_cfg_assertions u_assertions (
    .clk      (clk),
    .reset    (reset),
    .wst_req  (wst_req),
    .wst_rsp  (wst_rsp),
    .est_req  (est_req),
    .bank_req (bank_req),
    .bank_rd  (bank_rd)
);

`default_nettype wire

//--- dv/tb_glb_sram_cfg.sv
/*
 * Testbench for the configuration chain, driving tile 0 from the west edge.
 * Runs a directed bank sweep, clock enable checks, pipelined reads, then seeded
 * random traffic. Reads go only into free return slots, because the DUT has
 * no back-pressure. Only words written with their clock enable high are read.
 */
`timescale 1ns/1ps
`default_nettype none

module tb_glb_sram_cfg
    import glb_cfg_pkg::*;
();

    localparam int          NUM_OPS        = 1500;
    localparam int          TIMEOUT_CYCLES = (NUM_OPS + 20) * 4;
    localparam int          RESET_CYCLES   = 5;
    localparam int          SLOT_DEPTH     = 16;  // Deeper than the longest return of 8
    localparam int          MEM_WORDS      = 1 << CFG_ADDR_WIDTH;
    localparam logic [31:0] SEED           = 32'hc5b3_0714;

    typedef struct packed {
        int        ret_cycle;
        cfg_addr_t addr;
        cfg_data_t data;
    } rd_entry_t;

    logic     clk;
    logic     reset;
    cfg_req_t req;
    cfg_rsp_t rsp;

    int        cycle  = 0;
    int        errors = 0;
    cfg_data_t model     [MEM_WORDS];
    logic      written   [MEM_WORDS];   // Word holds a known value
    int        rd_busy   [MEM_WORDS];   // Reads in flight per address
    logic      slot_busy [SLOT_DEPTH];  // Return cycle already claimed
    rd_entry_t pending   [$];
    cfg_addr_t known_q   [$];

    glb_sram_cfg_chain u_dut (
        .clk     (clk),
        .reset   (reset),
        .wst_req (req),
        .wst_rsp (rsp)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Cycle count and run limit
    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Result: FAILED");
            $fatal(1, "Run stopped by the cycle limit");
        end
    end

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (actual !== expected) begin
            errors++;
            $display("** Error at %0t: %s expected 0x%0h, actual 0x%0h",
                     $time, name, expected, actual);
            $display("Result: FAILED");
            $fatal(1, "Value mismatch on %s", name);
        end
    endtask

    function automatic int tile_of(cfg_addr_t addr);
        return int'(addr[TILE_SEL_LSB +: TILE_SEL_ADDR_WIDTH]);
    endfunction

    // Two cycles per hop out and back, plus bank and return register
    function automatic int return_cycle(cfg_addr_t addr);
        return cycle + 2 * tile_of(addr) + 2;
    endfunction

    function automatic logic slot_free(cfg_addr_t addr);
        return !slot_busy[return_cycle(addr) % SLOT_DEPTH];
    endfunction

    function automatic cfg_addr_t make_addr(int tile, int bank, bank_addr_t offset);
        cfg_addr_t addr;
        addr = '0;
        addr[TILE_SEL_LSB +: TILE_SEL_ADDR_WIDTH] = tile_id_t'(tile);
        addr[BANK_SEL_LSB +: BANK_SEL_ADDR_WIDTH] = BANK_SEL_ADDR_WIDTH'(bank);
        addr[BANK_ADDR_WIDTH-1:0]                 = offset;
        return addr;
    endfunction

    // Inputs change 1 ns after the rising edge and idle by default
    task automatic next_cycle();
        @(posedge clk);
        #1;
        req = '0;
    endtask

    task automatic drive_write(cfg_addr_t addr, cfg_data_t data, logic clk_en);
        req.wr_en     = 1'b1;
        req.wr_clk_en = clk_en;
        req.wr_addr   = addr;
        req.wr_data   = data;
        if (clk_en) begin
            if (!written[addr]) begin
                known_q.push_back(addr);
            end
            model[addr]   = data;
            written[addr] = 1'b1;
        end
    endtask

    task automatic drive_read(cfg_addr_t addr, logic clk_en);
        rd_entry_t entry;
        req.rd_en     = 1'b1;
        req.rd_clk_en = clk_en;
        req.rd_addr   = addr;
        if (clk_en) begin
            entry.ret_cycle = return_cycle(addr);
            entry.addr      = addr;
            entry.data      = model[addr];  // Model as it stands at issue
            slot_busy[entry.ret_cycle % SLOT_DEPTH] = 1'b1;
            rd_busy[addr]++;
            pending.push_back(entry);
        end
    endtask

    task automatic read_back(cfg_addr_t addr);
        next_cycle();
        while (!slot_free(addr)) begin
            next_cycle();
        end
        drive_read(addr, 1'b1);
    endtask

    task automatic wait_returns();
        while (pending.size() != 0) begin
            next_cycle();
        end
    endtask

    // Valid is checked every cycle, so a missing or stray pulse fails at once
    task automatic check_return();
        int   slot;
        logic expect_valid;
        slot         = cycle % SLOT_DEPTH;
        expect_valid = slot_busy[slot];
        check_value("wst_rsp.rd_data_valid", 64'(expect_valid), 64'(rsp.rd_data_valid));
        if (expect_valid) begin
            for (int i = 0; i < pending.size(); i++) begin
                if (pending[i].ret_cycle == cycle) begin
                    check_value("wst_rsp.rd_data", 64'(pending[i].data), 64'(rsp.rd_data));
                    rd_busy[pending[i].addr]--;
                    pending.delete(i);
                    break;
                end
            end
            slot_busy[slot] = 1'b0;
        end
    endtask

    always @(negedge clk) begin
        if (!reset) begin
            check_return();
        end
    end

    // Same offset in every bank of every tile, each with its own word
    task automatic bank_sweep();
        bank_addr_t offset;
        offset = bank_addr_t'($urandom);
        for (int t = 0; t < NUM_TILES; t++) begin
            for (int b = 0; b < BANKS_PER_TILE; b++) begin
                next_cycle();
                drive_write(make_addr(t, b, offset), cfg_data_t'($urandom), 1'b1);
            end
        end
        for (int t = 0; t < NUM_TILES; t++) begin
            for (int b = 0; b < BANKS_PER_TILE; b++) begin
                read_back(make_addr(t, b, offset));
            end
        end
        wait_returns();
    endtask

    task automatic clock_enable_checks();
        cfg_addr_t addr;
        for (int t = 0; t < NUM_TILES; t++) begin
            addr = make_addr(t, t % BANKS_PER_TILE, bank_addr_t'($urandom));
            next_cycle();
            drive_write(addr, cfg_data_t'($urandom), 1'b1);
            next_cycle();
            drive_write(addr, ~model[addr], 1'b0);  // Dropped, old word stays
            read_back(addr);
            wait_returns();
        end
        for (int t = 0; t < NUM_TILES; t++) begin
            next_cycle();
            drive_read(make_addr(t, 0, bank_addr_t'($urandom)), 1'b0);
        end
        repeat (2 * NUM_TILES + 4) next_cycle();  // No pulse may appear here
    endtask

    // Far tile first, so all returns land in distinct cycles
    task automatic pipelined_reads();
        bank_addr_t offset;
        for (int b = 0; b < BANKS_PER_TILE; b++) begin
            offset = bank_addr_t'($urandom);
            for (int t = 0; t < NUM_TILES; t++) begin
                next_cycle();
                drive_write(make_addr(t, b, offset), cfg_data_t'($urandom), 1'b1);
            end
            wait_returns();
            for (int t = NUM_TILES - 1; t >= 0; t--) begin
                read_back(make_addr(t, b, offset));
            end
            wait_returns();
        end
    endtask

    task automatic random_traffic();
        cfg_addr_t addr;
        int        pick;
        logic      en;
        for (int n = 0; n < NUM_OPS; n++) begin
            next_cycle();
            pick = $urandom_range(99, 0);
            en   = ($urandom_range(9, 0) != 0);
            if (pick < 45) begin
                addr = cfg_addr_t'($urandom);
                if (rd_busy[addr] == 0) begin
                    drive_write(addr, cfg_data_t'($urandom), en);
                end
            end else if (pick < 90 && known_q.size() > 0) begin
                addr = known_q[$urandom_range(known_q.size() - 1, 0)];
                if (!en || slot_free(addr)) begin
                    drive_read(addr, en);
                end
            end
        end
    endtask

    initial begin
        void'($urandom(SEED));
        req   = '0;
        reset = 1'b1;
        for (int a = 0; a < MEM_WORDS; a++) begin
            written[a] = 1'b0;
            rd_busy[a] = 0;
        end
        for (int s = 0; s < SLOT_DEPTH; s++) begin
            slot_busy[s] = 1'b0;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        reset = 1'b0;
        repeat (6) next_cycle();  // Quiet return path before any read

        bank_sweep();
        clock_enable_checks();
        pipelined_reads();
        random_traffic();
        wait_returns();
        repeat (2 * NUM_TILES + 4) next_cycle();

        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- filelist.f
src/glb_cfg_pkg.sv
src/glb_sram_bank.sv
src/glb_sram_cfg_ctrl.sv
src/glb_tile.sv
src/glb_sram_cfg_chain.sv
dv/glb_sram_cfg_assertions.sv
dv/tb_glb_sram_cfg.sv

//--- Makefile
# Verilator build and run of the global buffer configuration chain testbench

VERILATOR ?= verilator
TOP       ?= tb_glb_sram_cfg
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert -j $(JOBS)
PASS_MSG  := Result: PASSED

SIM := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and look for the pass message"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR JOBS VFLAGS"

$(SIM): $(shell cat $(FILELIST)) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(SIM)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	if echo "$$out" | grep -qx "$(PASS_MSG)"; then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR)
